/* logic/wisc_pkg.sv */
// Shared ISA definitions; opcodes 7, 13 and 14 decode as no-ops and all addresses are word addresses
package wisc_pkg;

	localparam int DATA_W = 16;
	localparam int REG_W  = 4;
	localparam int ADDR_W = 16;

	localparam logic [3:0] OP_ADD = 4'd0;
	localparam logic [3:0] OP_SUB = 4'd1;
	localparam logic [3:0] OP_AND = 4'd2;
	localparam logic [3:0] OP_NOR = 4'd3;
	localparam logic [3:0] OP_SLL = 4'd4;
	localparam logic [3:0] OP_SRL = 4'd5;
	localparam logic [3:0] OP_SRA = 4'd6;
	localparam logic [3:0] OP_LW  = 4'd8;
	localparam logic [3:0] OP_SW  = 4'd9;
	localparam logic [3:0] OP_LHB = 4'd10;
	localparam logic [3:0] OP_LLB = 4'd11;
	localparam logic [3:0] OP_B   = 4'd12;
	localparam logic [3:0] OP_HLT = 4'd15;

	localparam logic [2:0] CND_NE = 3'd0;
	localparam logic [2:0] CND_EQ = 3'd1;
	localparam logic [2:0] CND_GT = 3'd2;
	localparam logic [2:0] CND_LT = 3'd3;
	localparam logic [2:0] CND_GE = 3'd4;
	localparam logic [2:0] CND_LE = 3'd5;
	localparam logic [2:0] CND_OV = 3'd6;
	localparam logic [2:0] CND_AL = 3'd7;

	typedef struct packed {
		logic [3:0]       opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;      // rt, or shift amount for shifts
	} instr_r_t;

	typedef struct packed {
		logic [3:0]       opcode;
		logic [REG_W-1:0] rt;      // Load dest or store data
		logic [REG_W-1:0] rs;      // Base register
		logic [3:0]       offset;  // Signed word offset
	} instr_m_t;

	typedef struct packed {
		logic [3:0]       opcode;
		logic [REG_W-1:0] rd;
		logic [7:0]       imm;
	} instr_i_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [2:0] cond;
		logic [8:0] offset;        // Signed, relative to pc + 1
	} instr_b_t;

	typedef union packed {
		instr_r_t r;
		instr_m_t m;
		instr_i_t i;
		instr_b_t b;
	} instr_u;

endpackage

/* logic/fetch_unit.sv */
// Program load is accepted only while rst is high; PC indexes IMEM_DEPTH words and wraps
`timescale 1ns/1ps

module fetch_unit import wisc_pkg::*; #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              prog_we,
	input  logic [ADDR_W-1:0] prog_addr,
	input  logic [DATA_W-1:0] prog_data,
	input  logic              stall,
	input  logic              halt_fetch,
	input  logic              br_taken,
	input  logic [ADDR_W-1:0] br_target,
	output instr_u            if_instr,
	output logic [ADDR_W-1:0] if_pc,
	output logic              if_valid
);

	localparam int IDX_W = $clog2(IMEM_DEPTH);

	logic [DATA_W-1:0] imem [IMEM_DEPTH];
	logic [ADDR_W-1:0] pc;
	logic              hold;

	assign hold = stall || halt_fetch;

	always_ff @(posedge clk) begin
		if (rst && prog_we) begin
			imem[prog_addr[IDX_W-1:0]] <= prog_data;  // Harness load port
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= '0;
			if_valid <= 1'b0;
		end else if (br_taken) begin
			pc       <= br_target;  // Redirect, drop the word in flight
			if_valid <= 1'b0;
		end else if (!hold) begin
			pc       <= pc + 1'b1;
			if_valid <= 1'b1;
		end
	end

	// IF/ID payload, frozen while decode holds
	always_ff @(posedge clk) begin
		if (!br_taken && !hold) begin
			if_instr <= imem[pc[IDX_W-1:0]];
			if_pc    <= pc;
		end
	end

endmodule

/* logic/decode_unit.sv */
// Stalls on ID/EX and EX/MEM producers only; the MEM/WB write is passed through to the reads
`timescale 1ns/1ps

module decode_unit import wisc_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  instr_u            if_instr,
	input  logic [ADDR_W-1:0] if_pc,
	input  logic              if_valid,
	input  logic              br_taken,
	input  logic [REG_W-1:0]  ex_rd,
	input  logic              ex_reg_we,
	input  logic [REG_W-1:0]  mem_rd_in,
	input  logic              mem_reg_we_in,
	input  logic              wb_valid,
	input  logic [REG_W-1:0]  wb_reg,
	input  logic [DATA_W-1:0] wb_data,
	output logic              stall,
	output logic              halt_fetch,
	output logic              id_valid,
	output instr_u            id_instr,
	output logic [ADDR_W-1:0] id_pc,
	output logic [DATA_W-1:0] id_rs_data,
	output logic [DATA_W-1:0] id_rt_data,
	output logic [DATA_W-1:0] id_imm,
	output logic [3:0]        id_alu_op,
	output logic              id_alu_src,
	output logic              id_reg_we,
	output logic              id_mem_we,
	output logic              id_mem_re,
	output logic              id_branch,
	output logic              id_half,
	output logic              id_half_hi,
	output logic [REG_W-1:0]  id_rd,
	output logic              id_hlt
);

	logic [DATA_W-1:0] regs [2**REG_W];
	logic [3:0]        opc;
	logic              is_rrr, is_shift, is_lw, is_sw, is_half;
	logic              use_rs, use_rt, hazard, hlt_now, halted, bubble;
	logic [REG_W-1:0]  ra, rb, dst;
	logic [DATA_W-1:0] imm;

	// r0 reads zero and a write in MEM/WB this cycle is seen at once
	function automatic logic [DATA_W-1:0] read_port(input logic [REG_W-1:0] a);
		if (a == '0) begin
			return '0;
		end else if (mem_reg_we_in && mem_rd_in == a) begin
			return wb_data;
		end
		return regs[a];
	endfunction

	// Source waits on an older producer still in ID/EX or EX/MEM
	function automatic logic pending(input logic [REG_W-1:0] src);
		logic in_idex, in_exmem;
		in_idex  = id_valid && id_reg_we && id_rd == src;
		in_exmem = ex_reg_we && ex_rd == src;
		return src != '0 && (in_idex || in_exmem);
	endfunction

	always_comb begin
		opc      = if_instr.r.opcode;
		is_rrr   = opc inside {OP_ADD, OP_SUB, OP_AND, OP_NOR};
		is_shift = opc inside {OP_SLL, OP_SRL, OP_SRA};
		is_lw    = opc == OP_LW;
		is_sw    = opc == OP_SW;
		is_half  = opc inside {OP_LHB, OP_LLB};

		ra = if_instr.r.rs;
		if (is_sw) begin
			rb = if_instr.m.rt;  // Store data
		end else if (is_half) begin
			rb = if_instr.i.rd;  // Byte merge keeps the other half
		end else begin
			rb = if_instr.r.rt;
		end

		dst = if_instr.r.rd;  // Bits 11:8 in the r, m and i views alike

		if (is_shift) begin
			imm = {{(DATA_W-REG_W){1'b0}}, if_instr.r.rt};
		end else if (is_half) begin
			imm = {{(DATA_W-8){1'b0}}, if_instr.i.imm};
		end else begin
			imm = {{(DATA_W-4){if_instr.m.offset[3]}}, if_instr.m.offset};
		end

		use_rs = is_rrr || is_shift || is_lw || is_sw;
		use_rt = is_rrr || is_sw || is_half;
		hazard = (use_rs && pending(ra)) || (use_rt && pending(rb));
	end

	assign hlt_now    = if_valid && !halted && !br_taken && opc == OP_HLT;
	assign halt_fetch = halted || hlt_now;
	assign stall      = if_valid && !halted && hazard;
	assign bubble     = !if_valid || halted || hazard || br_taken;

	always_ff @(posedge clk) begin
		if (wb_valid) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// ID/EX control
	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid  <= 1'b0;
			id_reg_we <= 1'b0;
			id_mem_we <= 1'b0;
			id_mem_re <= 1'b0;
			id_branch <= 1'b0;
			id_hlt    <= 1'b0;
			halted    <= 1'b0;
		end else begin
			id_valid  <= !bubble;
			id_reg_we <= !bubble && (is_rrr || is_shift || is_lw || is_half);
			id_mem_we <= !bubble && is_sw;
			id_mem_re <= !bubble && is_lw;
			id_branch <= !bubble && opc == OP_B;
			id_hlt    <= !bubble && opc == OP_HLT;
			if (hlt_now) begin
				halted <= 1'b1;  // Fetch stays stopped until reset
			end
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		id_instr   <= if_instr;
		id_pc      <= if_pc;
		id_rs_data <= read_port(ra);
		id_rt_data <= read_port(rb);
		id_imm     <= imm;
		id_alu_op  <= (is_rrr || is_shift) ? opc : OP_ADD;  // Address sum for LW/SW
		id_alu_src <= is_shift || is_lw || is_sw;
		id_half    <= is_half;
		id_half_hi <= opc == OP_LHB;
		id_rd      <= dst;
	end

endmodule

/* logic/execute_unit.sv */
// Flags change only on valid ALU opcodes; V is written by ADD and SUB alone
`timescale 1ns/1ps

module execute_unit import wisc_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              id_valid,
	input  instr_u            id_instr,
	input  logic [ADDR_W-1:0] id_pc,
	input  logic [DATA_W-1:0] id_rs_data,
	input  logic [DATA_W-1:0] id_rt_data,
	input  logic [DATA_W-1:0] id_imm,
	input  logic [3:0]        id_alu_op,
	input  logic              id_alu_src,
	input  logic              id_reg_we,
	input  logic              id_mem_we,
	input  logic              id_mem_re,
	input  logic              id_branch,
	input  logic              id_half,
	input  logic              id_half_hi,
	input  logic [REG_W-1:0]  id_rd,
	input  logic              id_hlt,
	output logic              br_taken,
	output logic [ADDR_W-1:0] br_target,
	output logic              ex_valid,
	output logic              ex_reg_we,
	output logic              ex_mem_we,
	output logic              ex_mem_re,
	output logic [REG_W-1:0]  ex_rd,
	output logic [DATA_W-1:0] ex_alu,
	output logic [DATA_W-1:0] ex_sw_data,
	output logic              ex_hlt
);

	logic [DATA_W-1:0] opnd_b, sum, diff, alu_res;
	logic              add_v, sub_v, cond_ok, sets_flags;
	logic              flag_z, flag_n, flag_v;

	always_comb begin
		opnd_b = id_alu_src ? id_imm : id_rt_data;
		sum    = id_rs_data + opnd_b;
		diff   = id_rs_data - opnd_b;
		add_v  = (id_rs_data[DATA_W-1] == opnd_b[DATA_W-1]) &&
		         (sum[DATA_W-1] != id_rs_data[DATA_W-1]);
		sub_v  = (id_rs_data[DATA_W-1] != opnd_b[DATA_W-1]) &&
		         (diff[DATA_W-1] != id_rs_data[DATA_W-1]);

		case (id_alu_op)
			OP_SUB:  alu_res = diff;
			OP_AND:  alu_res = id_rs_data & opnd_b;
			OP_NOR:  alu_res = ~(id_rs_data | opnd_b);
			OP_SLL:  alu_res = id_rs_data << opnd_b[3:0];
			OP_SRL:  alu_res = id_rs_data >> opnd_b[3:0];
			OP_SRA:  alu_res = $signed(id_rs_data) >>> opnd_b[3:0];
			default: alu_res = sum;  // ADD and memory address
		endcase
		if (id_half) begin
			alu_res = id_half_hi ? {id_imm[7:0], id_rt_data[7:0]}
			                     : {id_rt_data[DATA_W-1:8], id_imm[7:0]};
		end
	end

	assign sets_flags = id_valid && (id_instr.r.opcode inside
		{OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_SLL, OP_SRL, OP_SRA});

	always_comb begin
		case (id_instr.b.cond)
			CND_NE:  cond_ok = !flag_z;
			CND_EQ:  cond_ok = flag_z;
			CND_GT:  cond_ok = !flag_z && !flag_n;
			CND_LT:  cond_ok = flag_n;
			CND_GE:  cond_ok = !flag_n;
			CND_LE:  cond_ok = flag_n || flag_z;
			CND_OV:  cond_ok = flag_v;
			default: cond_ok = 1'b1;  // Always
		endcase
	end

	// id_branch is already cleared on bubbles
	assign br_taken  = id_branch && cond_ok;
	assign br_target = id_pc + 1'b1 + {{(ADDR_W-9){id_instr.b.offset[8]}}, id_instr.b.offset};

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
		end else if (sets_flags) begin
			flag_z <= alu_res == '0;
			flag_n <= alu_res[DATA_W-1];
			if (id_instr.r.opcode == OP_ADD) begin
				flag_v <= add_v;
			end else if (id_instr.r.opcode == OP_SUB) begin
				flag_v <= sub_v;
			end
		end
	end

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid  <= 1'b0;
			ex_reg_we <= 1'b0;
			ex_mem_we <= 1'b0;
			ex_mem_re <= 1'b0;
			ex_hlt    <= 1'b0;
		end else begin
			ex_valid  <= id_valid;
			ex_reg_we <= id_reg_we;
			ex_mem_we <= id_mem_we;
			ex_mem_re <= id_mem_re;
			ex_hlt    <= id_hlt;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd      <= id_rd;
		ex_alu     <= alu_res;
		ex_sw_data <= id_rt_data;
	end

endmodule

/* logic/memory_unit.sv */
// Data memory holds DMEM_DEPTH words; higher address bits are ignored
`timescale 1ns/1ps

module memory_unit import wisc_pkg::*; #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              ex_valid,
	input  logic              ex_reg_we,
	input  logic              ex_mem_we,
	input  logic              ex_mem_re,
	input  logic [REG_W-1:0]  ex_rd,
	input  logic [DATA_W-1:0] ex_alu,
	input  logic [DATA_W-1:0] ex_sw_data,
	input  logic              ex_hlt,
	output logic              mem_reg_we,
	output logic              mem_to_reg,
	output logic [REG_W-1:0]  mem_rd,
	output logic [DATA_W-1:0] mem_rdata,
	output logic [DATA_W-1:0] mem_alu,
	output logic              mem_hlt
);

	localparam int IDX_W = $clog2(DMEM_DEPTH);

	logic [DATA_W-1:0] dmem [DMEM_DEPTH];
	logic [IDX_W-1:0]  idx;

	assign idx = ex_alu[IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (ex_valid && ex_mem_we) begin
			dmem[idx] <= ex_sw_data;  // SW
		end
	end

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_reg_we <= 1'b0;
			mem_to_reg <= 1'b0;
			mem_hlt    <= 1'b0;
		end else begin
			mem_reg_we <= ex_valid && ex_reg_we;
			mem_to_reg <= ex_valid && ex_mem_re;
			mem_hlt    <= ex_valid && ex_hlt;
		end
	end

	always_ff @(posedge clk) begin
		mem_rd    <= ex_rd;
		mem_rdata <= dmem[idx];  // Loaded word for LW
		mem_alu   <= ex_alu;
	end

endmodule

/* logic/wisc_pipeline.sv */
// Load the program while rst is high; hlt stays high until the next reset
`timescale 1ns/1ps

module wisc_pipeline import wisc_pkg::*; #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              prog_we,
	input  logic [ADDR_W-1:0] prog_addr,
	input  logic [DATA_W-1:0] prog_data,
	output logic              wb_valid,
	output logic [REG_W-1:0]  wb_reg,
	output logic [DATA_W-1:0] wb_data,
	output logic              hlt
);

	logic              rst_g;
	logic              hlt_q;
	instr_u            if_instr, id_instr;
	logic [ADDR_W-1:0] if_pc, id_pc, br_target;
	logic              if_valid, stall, halt_fetch, br_taken;
	logic              id_valid, id_alu_src, id_reg_we, id_mem_we, id_mem_re;
	logic              id_branch, id_half, id_half_hi, id_hlt;
	logic [DATA_W-1:0] id_rs_data, id_rt_data, id_imm;
	logic [3:0]        id_alu_op;
	logic [REG_W-1:0]  id_rd, ex_rd, mem_rd;
	logic              ex_valid, ex_reg_we, ex_mem_we, ex_mem_re, ex_hlt;
	logic [DATA_W-1:0] ex_alu, ex_sw_data, mem_rdata, mem_alu;
	logic              mem_reg_we, mem_to_reg, mem_hlt;

	always_ff @(posedge clk) begin
		rst_g <= rst;  // Registered reset for all stages
	end

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch0 (
		.clk(clk), .rst(rst_g),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.stall(stall), .halt_fetch(halt_fetch),
		.br_taken(br_taken), .br_target(br_target),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid)
	);

	decode_unit decode0 (
		.clk(clk), .rst(rst_g),
		.if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid), .br_taken(br_taken),
		.ex_rd(ex_rd), .ex_reg_we(ex_reg_we),
		.mem_rd_in(mem_rd), .mem_reg_we_in(mem_reg_we),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.stall(stall), .halt_fetch(halt_fetch),
		.id_valid(id_valid), .id_instr(id_instr), .id_pc(id_pc),
		.id_rs_data(id_rs_data), .id_rt_data(id_rt_data), .id_imm(id_imm),
		.id_alu_op(id_alu_op), .id_alu_src(id_alu_src), .id_reg_we(id_reg_we),
		.id_mem_we(id_mem_we), .id_mem_re(id_mem_re), .id_branch(id_branch),
		.id_half(id_half), .id_half_hi(id_half_hi), .id_rd(id_rd), .id_hlt(id_hlt)
	);

	execute_unit execute0 (
		.clk(clk), .rst(rst_g),
		.id_valid(id_valid), .id_instr(id_instr), .id_pc(id_pc),
		.id_rs_data(id_rs_data), .id_rt_data(id_rt_data), .id_imm(id_imm),
		.id_alu_op(id_alu_op), .id_alu_src(id_alu_src), .id_reg_we(id_reg_we),
		.id_mem_we(id_mem_we), .id_mem_re(id_mem_re), .id_branch(id_branch),
		.id_half(id_half), .id_half_hi(id_half_hi), .id_rd(id_rd), .id_hlt(id_hlt),
		.br_taken(br_taken), .br_target(br_target),
		.ex_valid(ex_valid), .ex_reg_we(ex_reg_we), .ex_mem_we(ex_mem_we),
		.ex_mem_re(ex_mem_re), .ex_rd(ex_rd), .ex_alu(ex_alu),
		.ex_sw_data(ex_sw_data), .ex_hlt(ex_hlt)
	);

	memory_unit #(.DMEM_DEPTH(DMEM_DEPTH)) memory0 (
		.clk(clk), .rst(rst_g),
		.ex_valid(ex_valid), .ex_reg_we(ex_reg_we), .ex_mem_we(ex_mem_we),
		.ex_mem_re(ex_mem_re), .ex_rd(ex_rd), .ex_alu(ex_alu),
		.ex_sw_data(ex_sw_data), .ex_hlt(ex_hlt),
		.mem_reg_we(mem_reg_we), .mem_to_reg(mem_to_reg), .mem_rd(mem_rd),
		.mem_rdata(mem_rdata), .mem_alu(mem_alu), .mem_hlt(mem_hlt)
	);

	// Writeback stage
	assign wb_valid = mem_reg_we && mem_rd != '0;  // r0 writes are dropped
	assign wb_reg   = mem_rd;
	assign wb_data  = mem_to_reg ? mem_rdata : mem_alu;

	always_ff @(posedge clk) begin
		if (rst_g) begin
			hlt_q <= 1'b0;
		end else if (mem_hlt) begin
			hlt_q <= 1'b1;
		end
	end

	assign hlt = mem_hlt || hlt_q;  // Up in the cycle HLT retires

endmodule

/* dv/clk_gen.sv */
// Free-running testbench clock, starts low, period set by PERIOD in ns
`timescale 1ns/1ps

module clk_gen #(
	parameter real PERIOD = 8.0
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2.0) clk = ~clk;  // 8 ns period by default

endmodule

/* dv/wisc_tb.sv */
// Program must fit in the 16 reset cycles; registers start undefined, so r1 is built from r0
`timescale 1ns/1ps

module wisc_tb import wisc_pkg::*; ();

	localparam int RST_CYCLES  = 16;
	localparam int PROG_N      = 16;
	localparam int EXP_N       = 9;
	localparam int WB_TIMEOUT  = 40;  // Cycles allowed between two writebacks
	localparam int HLT_TIMEOUT = 40;
	localparam int QUIET_CYCLES = 8;  // Watch window after hlt

	// Program words, loaded at address = index
	localparam logic [DATA_W-1:0] PROG [PROG_N] = '{
		16'h3100,  // 0  NOR r1, r0, r0
		16'hB134,  // 1  LLB r1, 0x34
		16'h6514,  // 2  SRA r5, r1, 4
		16'h5614,  // 3  SRL r6, r1, 4
		16'hA112,  // 4  LHB r1, 0x12
		16'h4214,  // 5  SLL r2, r1, 4
		16'h2312,  // 6  AND r3, r1, r2
		16'h923F,  // 7  SW  r2, -1(r3)
		16'h873F,  // 8  LW  r7, -1(r3)
		16'h1072,  // 9  SUB r0, r7, r2
		16'hC004,  // 10 B NE, +4
		16'h0807,  // 11 ADD r8, r0, r7
		16'hC402,  // 12 B GT, +2
		16'h0911,  // 13 ADD r9, r1, r1
		16'h0A11,  // 14 ADD r10, r1, r1
		16'hF000   // 15 HLT
	};

	// Writebacks in program order, from the ISA rules
	localparam logic [REG_W-1:0] EXP_REG [EXP_N] = '{
		4'd1, 4'd1, 4'd5, 4'd6, 4'd1, 4'd2, 4'd3, 4'd7, 4'd8
	};

	localparam logic [DATA_W-1:0] EXP_DATA [EXP_N] = '{
		16'hFFFF,  // ~(0 | 0)
		16'hFF34,  // Low byte replaced
		16'hFFF3,  // 0xFF34 shifted right 4, sign filled
		16'h0FF3,  // 0xFF34 shifted right 4, zero filled
		16'h1234,  // High byte replaced
		16'h2340,
		16'h0200,  // 0x1234 & 0x2340
		16'h2340,  // Word stored at 0x01FF
		16'h2340   // r0 reads zero after the write at 9
	};

	logic              clk;
	logic              rst;
	logic              prog_we;
	logic [ADDR_W-1:0] prog_addr;
	logic [DATA_W-1:0] prog_data;
	logic              wb_valid;
	logic [REG_W-1:0]  wb_reg;
	logic [DATA_W-1:0] wb_data;
	logic              hlt;

	int mismatches;
	int other_errors;

	clk_gen #(.PERIOD(8.0)) clk_gen0 (
		.clk(clk)
	);

	wisc_pipeline dut0 (
		.clk(clk),
		.rst(rst),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.hlt(hlt)
	);

	task automatic check_reg(input string name, input logic [REG_W-1:0] got,
			input logic [REG_W-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// One word per rising edge; rst falls with the last word
	task automatic load_program();
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge clk);
			if (i < PROG_N) begin
				prog_we   <= 1'b1;
				prog_addr <= ADDR_W'(i);
				prog_data <= PROG[i];
			end else begin
				prog_we <= 1'b0;
			end
			if (i == RST_CYCLES - 1) begin
				rst <= 1'b0;
			end
		end
		@(posedge clk);
		prog_we <= 1'b0;
	endtask

	// Advances at least one cycle, then stops on the next writeback
	task automatic wait_writeback(output logic seen);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (hlt && !wb_valid) begin
				other_errors++;
				$display("hlt rose at %0t before all expected writebacks", $time);
				seen = 1'b0;
				return;
			end
		end while (!wb_valid && n < WB_TIMEOUT);
		seen = wb_valid;
	endtask

	task automatic wait_halt(output logic seen);
		int n;
		n = 0;
		while (!hlt && n < HLT_TIMEOUT) begin
			@(negedge clk);
			n++;
			if (wb_valid) begin
				other_errors++;
				$display("extra writeback at %0t to register %0d", $time, wb_reg);
			end
		end
		seen = hlt;
	endtask

	task automatic watch_after_halt();
		for (int n = 0; n < QUIET_CYCLES; n++) begin
			@(negedge clk);
			if (wb_valid) begin
				other_errors++;
				$display("writeback at %0t after hlt, register %0d", $time, wb_reg);
			end
			if (!hlt) begin
				other_errors++;
				$display("hlt dropped at %0t before reset", $time);
			end
		end
	endtask

	initial begin
		logic seen;
		int   idx;

		rst          = 1'b1;
		prog_we      = 1'b0;
		prog_addr    = '0;
		prog_data    = '0;
		mismatches   = 0;
		other_errors = 0;
		seen         = 1'b1;

		load_program();

		idx = 0;
		while (idx < EXP_N && seen) begin
			wait_writeback(seen);
			if (seen) begin
				check_reg("wb_reg", wb_reg, EXP_REG[idx]);
				check_data("wb_data", wb_data, EXP_DATA[idx]);
				idx++;
			end else if (!hlt) begin
				other_errors++;
				$display("timeout waiting for writeback %0d of %0d", idx + 1, EXP_N);
			end
		end

		if (seen) begin
			wait_halt(seen);
			if (seen) begin
				watch_after_halt();
			end else begin
				other_errors++;
				$display("timeout waiting for hlt after the last writeback");
			end
		end

		$display("errors: mismatches %0d, other %0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* vlog.f */
logic/wisc_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/wisc_pipeline.sv
dv/clk_gen.sv
dv/wisc_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module wisc_tb \
	-f vlog.f -o wisc_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/wisc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
